/* bench/fpu_tb_tasks.svh */
// APB access tasks, random operands and the reference multiply for fpu_tb.
// Included inside fpu_tb; relies on its clock, APB signals and check_value.
// The model treats subnormal inputs as zero and flushes tiny results.

// One APB write; the transfer completes on the rising edge after penable rises.
task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                         input logic exp_err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    // Sampled well before the rising edge, while the access phase is stable.
    #1;
    check_value("pready", 32'd1, 32'(pready));
    check_value("pslverr", 32'(exp_err), 32'(pslverr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// One APB read with the same phase timing as the write.
task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                        input logic exp_err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    check_value("pready", 32'd1, 32'(pready));
    check_value("pslverr", 32'(exp_err), 32'(pslverr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// Linear congruential generator, full 32-bit state.
function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// A normal operand with a biased exponent from 64 to 190.
// The products then stay clear of overflow and underflow.
function automatic logic [31:0] random_operand();
    int unsigned r;
    int unsigned ex;
    r  = lcg_next();
    ex = 64 + (lcg_next() % 127);
    // The upper bits of the LCG state are the better ones.
    return {r[31], 8'(ex), r[30:8]};
endfunction

// Reference product, returned as {overflow, underflow, inexact, value}.
function automatic logic [34:0] model_mul(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] rm);
    int          ea;
    int          eb;
    int          e;
    int          shift;
    logic        s;
    logic        inf_a;
    logic        inf_b;
    logic        nan_in;
    logic        inexact;
    logic        up;
    logic        away;
    logic [47:0] p;
    logic [47:0] rem;
    logic [47:0] half;
    logic [24:0] kept;
    s      = a[31] ^ b[31];
    ea     = int'(a[30:23]);
    eb     = int'(b[30:23]);
    inf_a  = (ea == 255) && (a[22:0] == 23'd0);
    inf_b  = (eb == 255) && (b[22:0] == 23'd0);
    nan_in = ((ea == 255) && !inf_a) || ((eb == 255) && !inf_b);
    if (nan_in || (inf_a && eb == 0) || (inf_b && ea == 0)) begin
        return {3'b000, 32'h7FC0_0000};
    end
    if (inf_a || inf_b) begin
        return {3'b000, s, 8'hFF, 23'd0};
    end
    if (ea == 0 || eb == 0) begin
        return {3'b000, s, 31'd0};
    end
    // Integer significand product, then split at the leading one.
    p     = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
    shift = p[47] ? 24 : 23;
    e     = ea + eb - 127 + (p[47] ? 1 : 0);
    kept  = 25'(p >> shift);
    rem   = p & ((48'd1 << shift) - 48'd1);
    half  = 48'd1 << (shift - 1);
    inexact = (rem != 48'd0);
    case (rm)
        3'd0:    up = (rem > half) || ((rem == half) && kept[0]);
        3'd2:    up = !s && inexact;
        3'd3:    up = s && inexact;
        3'd4:    up = (rem >= half);
        default: up = 1'b0;
    endcase
    kept = kept + 25'(up);
    // Rounding up to 2.0 moves the result one binade up.
    if (kept[24]) begin
        kept = kept >> 1;
        e    = e + 1;
    end
    if (e >= 255) begin
        case (rm)
            3'd0, 3'd4: away = 1'b1;
            3'd2:       away = !s;
            3'd3:       away = s;
            default:    away = 1'b0;
        endcase
        return {3'b101, away ? {s, 8'hFF, 23'd0} : {s, 31'h7F7F_FFFF}};
    end
    if (e <= 0) begin
        return {3'b011, s, 31'd0};
    end
    return {2'b00, inexact, s, 8'(e), kept[22:0]};
endfunction

/* bench/fpu_tb.sv */
// Testbench for fpu_top over APB, one operation at a time.
// Expected results come from model_mul in the included task file.
// Random operands use a fixed LCG seed, so every run is the same.

`timescale 1ns/1ps

module fpu_tb;

    logic                                clk;
    logic                                reset;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [fpu_regs_pkg::addr_width-1:0] paddr;
    logic [31:0]                         pwdata;
    logic [31:0]                         prdata;
    logic                                pready;
    logic                                pslverr;

    // Bookkeeping for the per-test lines and the summary.
    string       cur_test;
    int          error_count;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;
    int unsigned lcg_state;

    `include "fpu_tb_tasks.svh"

    fpu_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s (%s): expected %h, actual %h", cur_test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        if (error_count == test_start_errors) begin
            $display("test %s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", cur_test, error_count - test_start_errors);
            tests_failed++;
        end
    endtask

    // Loads both operands and writes CTRL with the start bit and the mode.
    task automatic start_op(input logic [31:0] a, input logic [31:0] b, input logic [2:0] mode);
        apb_write(fpu_regs_pkg::addr_op_a, a, 1'b0);
        apb_write(fpu_regs_pkg::addr_op_b, b, 1'b0);
        apb_write(fpu_regs_pkg::addr_ctrl, {23'd0, 1'b1, 5'd0, mode}, 1'b0);
    endtask

    // Polls STATUS until done, then reads RESULT. Gives up after 40 polls.
    task automatic wait_result(output logic [31:0] value, output logic [31:0] status);
        int          polls;
        logic [31:0] st;
        st    = '0;
        value = '0;
        polls = 0;
        while (!timed_out && !st[fpu_regs_pkg::status_done_bit] && polls < 40) begin
            apb_read(fpu_regs_pkg::addr_status, st, 1'b0);
            polls++;
        end
        status = st;
        if (!timed_out && !st[fpu_regs_pkg::status_done_bit]) begin
            $display("Timeout in %s: STATUS never reported done", cur_test);
            timed_out = 1'b1;
            error_count++;
        end else if (!timed_out) begin
            apb_read(fpu_regs_pkg::addr_result, value, 1'b0);
        end
    endtask

    // exp_flags is {underflow, overflow, inexact}, in STATUS bit order.
    task automatic run_and_check(input logic [31:0] a, input logic [31:0] b,
                                 input logic [2:0] mode, input logic [31:0] exp_value,
                                 input logic [2:0] exp_flags);
        logic [31:0] value;
        logic [31:0] status;
        if (!timed_out) begin
            start_op(a, b, mode);
            wait_result(value, status);
            check_value("result", exp_value, value);
            // Done set, busy clear, and the three flags.
            check_value("status", {27'd0, exp_flags, 2'b10}, status);
        end
    endtask

    task automatic check_op(input logic [31:0] a, input logic [31:0] b, input logic [2:0] mode);
        logic [34:0] expected;
        expected = model_mul(a, b, mode);
        run_and_check(a, b, mode, expected[31:0], {expected[33], expected[34], expected[32]});
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [31:0] status;
        logic [34:0] expected;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        reset       = 1'b1;
        lcg_state   = 32'd39844;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out   = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        begin_test("reset_status");
        apb_read(fpu_regs_pkg::addr_status, data, 1'b0);
        check_value("status", 32'd0, data);
        end_test();

        // Exact products do not depend on the mode.
        begin_test("exact_products");
        for (int m = 0; m < 5; m++) begin
            run_and_check(32'h3FC0_0000, 32'h4000_0000, 3'(m), 32'h4040_0000, 3'b000);
            run_and_check(32'hC040_0000, 32'h3E80_0000, 3'(m), 32'hBF40_0000, 3'b000);
        end
        end_test();

        begin_test("random_products");
        for (int i = 0; i < 40; i++) begin
            a = random_operand();
            b = random_operand();
            for (int m = 0; m < 5; m++) begin
                check_op(a, b, 3'(m));
            end
        end
        // The product is just below 2.0, so round-up carries into the exponent.
        run_and_check(32'h3FFF_FFFE, 32'h3F80_0001, 3'd0, 32'h4000_0000, 3'b001);
        for (int m = 0; m < 8; m++) begin
            check_op(32'h3FFF_FFFE, 32'h3F80_0001, 3'(m));
        end
        end_test();

        begin_test("overflow");
        for (int m = 0; m < 5; m++) begin
            check_op(32'h7F00_0000, 32'h4000_0000, 3'(m));
            check_op(32'h7F00_0000, 32'hC000_0000, 3'(m));
        end
        run_and_check(32'h7F00_0000, 32'h4000_0000, 3'd1, 32'h7F7F_FFFF, 3'b011);
        run_and_check(32'h7F00_0000, 32'hC000_0000, 3'd2, 32'hFF7F_FFFF, 3'b011);
        run_and_check(32'h7F00_0000, 32'hC000_0000, 3'd0, 32'hFF80_0000, 3'b011);
        end_test();

        begin_test("underflow_special");
        run_and_check(32'h0080_0000, 32'hBF00_0000, 3'd0, 32'h8000_0000, 3'b101);
        check_op(32'h0080_0000, 32'h3F00_0000, 3'd2);
        check_op(32'h8000_0000, 32'h4040_0000, 3'd0);
        check_op(32'h0000_0001, 32'h4040_0000, 3'd0);
        check_op(32'h7F80_0000, 32'hC000_0000, 3'd1);
        run_and_check(32'h7F80_0000, 32'h0000_0000, 3'd0, 32'h7FC0_0000, 3'b000);
        run_and_check(32'h7FC0_0001, 32'h3F80_0000, 3'd0, 32'h7FC0_0000, 3'b000);
        end_test();

        begin_test("apb_registers");
        apb_write(fpu_regs_pkg::addr_op_a, 32'h1234_5678, 1'b0);
        apb_write(fpu_regs_pkg::addr_op_b, 32'h9ABC_DEF0, 1'b0);
        apb_read(fpu_regs_pkg::addr_op_a, data, 1'b0);
        check_value("op_a", 32'h1234_5678, data);
        apb_read(fpu_regs_pkg::addr_op_b, data, 1'b0);
        check_value("op_b", 32'h9ABC_DEF0, data);
        // Start with round-to-nearest-away; only the mode reads back.
        apb_write(fpu_regs_pkg::addr_ctrl, 32'h0000_0104, 1'b0);
        apb_read(fpu_regs_pkg::addr_ctrl, data, 1'b0);
        check_value("ctrl", 32'h0000_0004, data);
        wait_result(data, status);
        apb_read(5'h14, data, 1'b1);
        apb_write(5'h18, 32'hFFFF_FFFF, 1'b1);
        apb_read(5'h02, data, 1'b1);
        end_test();

        // A second start lands while the first operation is still in flight.
        begin_test("start_while_busy");
        start_op(32'h3DCC_CCCD, 32'h3DCC_CCCD, 3'd2);
        apb_write(fpu_regs_pkg::addr_ctrl, 32'h0000_0101, 1'b1);
        wait_result(data, status);
        expected = model_mul(32'h3DCC_CCCD, 32'h3DCC_CCCD, 3'd2);
        check_value("result", expected[31:0], data);
        apb_read(fpu_regs_pkg::addr_ctrl, data, 1'b0);
        check_value("ctrl", 32'h0000_0002, data);
        end_test();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+bench
logic/fp_pkg.sv
logic/fpu_regs_pkg.sv
logic/grs_rounder.sv
logic/fp_mul_pipe.sv
logic/fpu_apb_regs.sv
logic/fpu_top.sv
bench/fpu_tb.sv

/* logic/fp_mul_pipe.sv */
// Two-stage binary32 multiplier, one operation per cycle, no back-pressure.
// Subnormal inputs count as zero and tiny results flush to a signed zero.
// All NaN results are the quiet NaN 0x7FC00000.

`timescale 1ns/1ps

module fp_mul_pipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  fp_pkg::fp32_t       issue_a,
    input  fp_pkg::fp32_t       issue_b,
    input  fp_pkg::round_mode_t issue_mode,
    output logic                res_valid,
    output fp_pkg::fp32_t       res_value,
    output logic                res_inexact,
    output logic                res_overflow,
    output logic                res_underflow
);

    fp_pkg::exp_t        exp_a;
    fp_pkg::exp_t        exp_b;
    fp_pkg::frac_t       frac_a;
    fp_pkg::frac_t       frac_b;
    logic                zero_a;
    logic                zero_b;
    logic                inf_a;
    logic                inf_b;
    logic                nan_a;
    logic                nan_b;
    fp_pkg::mant_t       mant_a;
    fp_pkg::mant_t       mant_b;

    // Stage 1 registers.
    logic                s1_valid;
    logic                s1_sign;
    logic signed [9:0]   s1_exp;
    fp_pkg::prod_t       s1_prod;
    fp_pkg::round_mode_t s1_mode;
    logic                s1_nan;
    logic                s1_inf;
    logic                s1_zero;

    // Stage 2 signals.
    logic                norm;
    fp_pkg::grs_t        grs_value;
    fp_pkg::mant_t       rounded;
    logic                round_carry;
    logic signed [9:0]   exp_final;
    logic                away;
    fp_pkg::fp32_t       next_value;
    logic                next_inexact;
    logic                next_overflow;
    logic                next_underflow;

    assign exp_a  = issue_a[30:23];
    assign exp_b  = issue_b[30:23];
    assign frac_a = issue_a[22:0];
    assign frac_b = issue_b[22:0];

    // Exponent 0 is zero whatever the fraction holds.
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);
    assign inf_a  = (exp_a == fp_pkg::exp_max) && (frac_a == '0);
    assign inf_b  = (exp_b == fp_pkg::exp_max) && (frac_b == '0);
    assign nan_a  = (exp_a == fp_pkg::exp_max) && (frac_a != '0);
    assign nan_b  = (exp_b == fp_pkg::exp_max) && (frac_b != '0);

    // The hidden bit is dropped for zeros so that their product is zero too.
    assign mant_a = {~zero_a, frac_a};
    assign mant_b = {~zero_b, frac_b};

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    // The exponent sum stays signed so that underflow shows up as a value <= 0.
    always_ff @(posedge clk) begin
        s1_sign <= issue_a[31] ^ issue_b[31];
        s1_exp  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                   - 10'(fp_pkg::exp_bias);
        s1_prod <= mant_a * mant_b;
        s1_mode <= issue_mode;
        // Infinity times zero has no meaningful value, like a NaN operand.
        s1_nan  <= nan_a | nan_b | (inf_a & zero_b) | (inf_b & zero_a);
        s1_inf  <= inf_a | inf_b;
        s1_zero <= zero_a | zero_b;
    end

    // A product of two normal significands lies in [1, 4), so at most one
    // right shift is needed.
    assign norm      = s1_prod[47];
    assign grs_value = norm ? {s1_prod[47:22], |s1_prod[21:0]}
                            : {s1_prod[46:21], |s1_prod[20:0]};

    grs_rounder #(
        .input_width  ($bits(fp_pkg::grs_t)),
        .output_width ($bits(fp_pkg::mant_t))
    ) rounder_i (
        .value_in     (grs_value),
        .sign_in      (s1_sign),
        .mode         (s1_mode),
        .value_out    (rounded),
        .overflow_out (round_carry)
    );

    // A rounding carry leaves exactly 2.0, which is 1.0 one exponent up.
    // The kept bits are then all zero, so the fraction already reads 1.0.
    assign exp_final = s1_exp + {9'd0, norm} + {9'd0, round_carry};

    // Whether overflow goes to infinity or stops at the largest finite value.
    always_comb begin
        case (s1_mode)
            fp_pkg::rm_rne, fp_pkg::rm_rna: away = 1'b1;
            fp_pkg::rm_rpi:                 away = ~s1_sign;
            fp_pkg::rm_rni:                 away = s1_sign;
            default:                        away = 1'b0;
        endcase
    end

    always_comb begin
        next_value     = {s1_sign, exp_final[7:0], rounded[22:0]};
        next_inexact   = |grs_value[2:0];
        next_overflow  = 1'b0;
        next_underflow = 1'b0;
        // Special operands decide the result outright and raise no flags.
        if (s1_nan) begin
            next_value   = fp_pkg::qnan;
            next_inexact = 1'b0;
        end else if (s1_inf) begin
            next_value   = {s1_sign, fp_pkg::exp_t'(fp_pkg::exp_max), 23'd0};
            next_inexact = 1'b0;
        end else if (s1_zero) begin
            next_value   = {s1_sign, 31'd0};
            next_inexact = 1'b0;
        end else if (exp_final >= fp_pkg::exp_max) begin
            next_value    = away ? {s1_sign, fp_pkg::exp_t'(fp_pkg::exp_max), 23'd0}
                                 : {s1_sign, fp_pkg::max_finite_mag[30:0]};
            next_overflow = 1'b1;
            next_inexact  = 1'b1;
        end else if (exp_final <= 0) begin
            next_value     = {s1_sign, 31'd0};
            next_underflow = 1'b1;
            next_inexact   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        res_value     <= next_value;
        res_inexact   <= next_inexact;
        res_overflow  <= next_overflow;
        res_underflow <= next_underflow;
    end

endmodule

/* logic/fp_pkg.sv */
// IEEE 754 binary32 widths, typed vectors and rounding modes.
// Subnormals are not represented, and every NaN is the single quiet NaN below.

package fp_pkg;

    // Field widths of a binary32 word.
    localparam int exp_width  = 8;
    localparam int frac_width = 23;
    localparam int mant_width = frac_width + 1;

    // A binary32 word: sign, biased exponent, stored fraction.
    typedef logic [31:0]                 fp32_t;
    typedef logic [exp_width-1:0]        exp_t;
    typedef logic [frac_width-1:0]       frac_t;

    // The significand with its hidden bit restored.
    typedef logic [mant_width-1:0]       mant_t;

    // Full product of two significands.
    typedef logic [2*mant_width-1:0]     prod_t;

    // Kept significand bits followed by guard, round and sticky.
    // The sticky bit already ORs every product bit below the round bit.
    typedef logic [mant_width+2:0]       grs_t;

    // Rounding mode as written by software.
    // Codes 5 to 7 are not listed and round toward zero.
    typedef enum logic [2:0] {
        rm_rne = 3'd0,
        rm_rtz = 3'd1,
        rm_rpi = 3'd2,
        rm_rni = 3'd3,
        rm_rna = 3'd4
    } round_mode_t;

    localparam int    exp_bias       = 127;
    localparam int    exp_max        = 255;
    localparam fp32_t qnan           = 32'h7FC0_0000;
    localparam fp32_t max_finite_mag = 32'h7F7F_FFFF;

endpackage

/* logic/fpu_apb_regs.sv */
// APB register block in front of the multiplier. No wait states.
// One operation at a time; operand and CTRL writes while busy get pslverr.
// STATUS and RESULT ignore writes.

`timescale 1ns/1ps

module fpu_apb_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [fpu_regs_pkg::addr_width-1:0] paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                issue_valid,
    output fp_pkg::fp32_t                       issue_a,
    output fp_pkg::fp32_t                       issue_b,
    output fp_pkg::round_mode_t                 issue_mode,
    input  logic                                res_valid,
    input  fp_pkg::fp32_t                       res_value,
    input  logic                                res_inexact,
    input  logic                                res_overflow,
    input  logic                                res_underflow
);

    fpu_regs_pkg::regs_state_t state;
    fp_pkg::fp32_t             op_a;
    fp_pkg::fp32_t             op_b;
    fp_pkg::round_mode_t       mode;
    fp_pkg::fp32_t             result;
    logic                      done;
    logic                      flag_inexact;
    logic                      flag_overflow;
    logic                      flag_underflow;
    logic                      access;
    logic                      busy;
    logic                      addr_mapped;
    logic                      holds_operand;
    logic                      blocked;
    logic                      wr_ok;
    logic                      start_cmd;

    // A transfer completes in the access phase; pready never drops.
    assign access = psel & penable;
    assign pready = 1'b1;
    assign busy   = (state == fpu_regs_pkg::st_busy);

    always_comb begin
        case (paddr)
            fpu_regs_pkg::addr_op_a, fpu_regs_pkg::addr_op_b, fpu_regs_pkg::addr_ctrl,
            fpu_regs_pkg::addr_status, fpu_regs_pkg::addr_result: addr_mapped = 1'b1;
            default: addr_mapped = 1'b0;
        endcase
    end

    // The operands and mode must not change under a running operation.
    assign holds_operand = (paddr == fpu_regs_pkg::addr_op_a)
                         | (paddr == fpu_regs_pkg::addr_op_b)
                         | (paddr == fpu_regs_pkg::addr_ctrl);
    assign blocked   = access & pwrite & busy & holds_operand;
    assign pslverr   = access & (~addr_mapped | blocked);
    assign wr_ok     = access & pwrite & addr_mapped & ~blocked;
    assign start_cmd = wr_ok & (paddr == fpu_regs_pkg::addr_ctrl)
                     & pwdata[fpu_regs_pkg::ctrl_start_bit];

    // The multiplier reads the held registers directly.
    assign issue_a    = op_a;
    assign issue_b    = op_b;
    assign issue_mode = mode;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= fpu_regs_pkg::st_idle;
            issue_valid    <= 1'b0;
            op_a           <= '0;
            op_b           <= '0;
            mode           <= fp_pkg::rm_rne;
            result         <= '0;
            done           <= 1'b0;
            flag_inexact   <= 1'b0;
            flag_overflow  <= 1'b0;
            flag_underflow <= 1'b0;
        end else begin
            // Issue is a single-cycle pulse the cycle after the start write.
            issue_valid <= start_cmd;
            if (wr_ok && paddr == fpu_regs_pkg::addr_op_a) begin
                op_a <= pwdata;
            end
            if (wr_ok && paddr == fpu_regs_pkg::addr_op_b) begin
                op_b <= pwdata;
            end
            if (wr_ok && paddr == fpu_regs_pkg::addr_ctrl) begin
                mode <= fp_pkg::round_mode_t'(
                    pwdata[fpu_regs_pkg::ctrl_mode_msb:fpu_regs_pkg::ctrl_mode_lsb]);
            end
            case (state)
                fpu_regs_pkg::st_idle: begin
                    if (start_cmd) begin
                        state <= fpu_regs_pkg::st_busy;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    if (res_valid) begin
                        state <= fpu_regs_pkg::st_idle;
                        done  <= 1'b1;
                    end
                end
            endcase
            // Every result is captured, since the multiplier cannot stall.
            if (res_valid) begin
                result         <= res_value;
                flag_inexact   <= res_inexact;
                flag_overflow  <= res_overflow;
                flag_underflow <= res_underflow;
            end
        end
    end

    // Read data follows paddr directly; unmapped offsets read as zero.
    always_comb begin
        prdata = '0;
        case (paddr)
            fpu_regs_pkg::addr_op_a:   prdata = op_a;
            fpu_regs_pkg::addr_op_b:   prdata = op_b;
            fpu_regs_pkg::addr_ctrl: begin
                prdata[fpu_regs_pkg::ctrl_mode_msb:fpu_regs_pkg::ctrl_mode_lsb] = mode;
            end
            fpu_regs_pkg::addr_status: begin
                prdata[fpu_regs_pkg::status_busy_bit]      = busy;
                prdata[fpu_regs_pkg::status_done_bit]      = done;
                prdata[fpu_regs_pkg::status_inexact_bit]   = flag_inexact;
                prdata[fpu_regs_pkg::status_overflow_bit]  = flag_overflow;
                prdata[fpu_regs_pkg::status_underflow_bit] = flag_underflow;
            end
            fpu_regs_pkg::addr_result: prdata = result;
            default:                   prdata = '0;
        endcase
    end

endmodule

/* logic/fpu_regs_pkg.sv */
// Register map of the APB front end of the multiplier.
// Addresses are byte addresses on a 5-bit bus; only word offsets are mapped.

package fpu_regs_pkg;

    localparam int addr_width = 5;

    // Word registers.
    localparam logic [addr_width-1:0] addr_op_a   = 5'h00;
    localparam logic [addr_width-1:0] addr_op_b   = 5'h04;
    localparam logic [addr_width-1:0] addr_ctrl   = 5'h08;
    localparam logic [addr_width-1:0] addr_status = 5'h0C;
    localparam logic [addr_width-1:0] addr_result = 5'h10;

    // CTRL fields. Start is a write-only strobe and reads back as 0.
    localparam int ctrl_mode_lsb  = 0;
    localparam int ctrl_mode_msb  = 2;
    localparam int ctrl_start_bit = 8;

    // STATUS fields.
    localparam int status_busy_bit      = 0;
    localparam int status_done_bit      = 1;
    localparam int status_inexact_bit   = 2;
    localparam int status_overflow_bit  = 3;
    localparam int status_underflow_bit = 4;

    // One operation in flight at most, so two states suffice.
    typedef enum logic {
        st_idle,
        st_busy
    } regs_state_t;

endpackage

/* logic/fpu_top.sv */
// Floating-point multiplier with its APB register front end.
// The result is ready about four cycles after a start write.

`timescale 1ns/1ps

module fpu_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [fpu_regs_pkg::addr_width-1:0] paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr
);

    // Issue side, from the registers to the multiplier.
    logic                issue_valid;
    fp_pkg::fp32_t       issue_a;
    fp_pkg::fp32_t       issue_b;
    fp_pkg::round_mode_t issue_mode;

    // Result side, back to the registers.
    logic                res_valid;
    fp_pkg::fp32_t       res_value;
    logic                res_inexact;
    logic                res_overflow;
    logic                res_underflow;

    fpu_apb_regs regs_i (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .issue_valid   (issue_valid),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_mode    (issue_mode),
        .res_valid     (res_valid),
        .res_value     (res_value),
        .res_inexact   (res_inexact),
        .res_overflow  (res_overflow),
        .res_underflow (res_underflow)
    );

    fp_mul_pipe mul_i (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_mode    (issue_mode),
        .res_valid     (res_valid),
        .res_value     (res_value),
        .res_inexact   (res_inexact),
        .res_overflow  (res_overflow),
        .res_underflow (res_underflow)
    );

endmodule

/* logic/grs_rounder.sv */
// Combinational guard/round/sticky rounder with five modes.
// input_width must be at least output_width; with no spare bits it passes through.
// The carry-out is reported, and the caller renormalizes.

`timescale 1ns/1ps

module grs_rounder #(
    parameter int input_width  = 27,
    parameter int output_width = 24
) (
    input  logic [input_width-1:0]  value_in,
    input  logic                    sign_in,
    input  fp_pkg::round_mode_t     mode,
    output logic [output_width-1:0] value_out,
    output logic                    overflow_out
);

    // Number of bits below the kept value.
    localparam int shift = input_width - output_width;

    logic [input_width+2:0]  value_ext;
    logic [output_width-1:0] kept;
    logic                    guard;
    logic                    round_bit;
    logic                    sticky;
    logic                    inexact;
    logic                    increment;
    logic [output_width:0]   sum;

    // Three zero bits are appended so that guard, round and sticky can be
    // sliced the same way even when fewer than three bits are dropped.
    assign value_ext = {value_in, 3'b000};
    assign kept      = value_ext[input_width+2 -: output_width];
    assign guard     = value_ext[shift+2];
    assign round_bit = value_ext[shift+1];
    assign sticky    = |value_ext[shift:0];
    assign inexact   = guard | round_bit | sticky;

    always_comb begin
        case (mode)
            // Above half, or exactly half with an odd kept value.
            fp_pkg::rm_rne: increment = guard & (kept[0] | round_bit | sticky);
            // Directed modes move away from zero only on their own side.
            fp_pkg::rm_rpi: increment = ~sign_in & inexact;
            fp_pkg::rm_rni: increment = sign_in & inexact;
            // Half or more rounds away from zero.
            fp_pkg::rm_rna: increment = guard;
            // Truncation, which also covers the unused codes.
            default:        increment = 1'b0;
        endcase
    end

    // One extra bit holds the carry out of the kept value.
    assign sum          = {1'b0, kept} + (output_width + 1)'(increment);
    assign value_out    = sum[output_width-1:0];
    assign overflow_out = sum[output_width];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpu_tb -f flist.f

output=$(./obj_dir/Vfpu_tb)
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1
